// ==== bank_ctrl.sv ====
// bank FSM that turns request edges into ACT, column and precharge commands and drives busy and ack
`default_nettype none

module bank_ctrl (
	input  wire                      clk,
	input  wire                      rst2,
	input  wire                      req,
	input  wire                      auto_prech,
	input  wire bank_pkg::timer_done_t tmr_done,
	input  wire                      burst_start,
	input  wire                      last_beat,
	input  wire bank_pkg::bank_req_t req_q,
	output logic                     start,
	output logic                     burst_go,
	output bank_pkg::timer_start_t   tmr_start,
	output sdram_pkg::sdr_cmd_e      cmd,
	output logic                     row_addr,
	output logic                     busy,
	output logic                     req_ack
);

	logic                  req_d;
	bank_pkg::bank_state_e state;
	bank_pkg::bank_state_e state_nxt;
	sdram_pkg::sdr_cmd_e   cmd_nxt;

	// edges seen while busy are dropped
	assign start    = req && !req_d && !busy;
	assign burst_go = (state == bank_pkg::write) || (state == bank_pkg::read);

	//////////////////////////////////////////////////////////////////////
	// timer loads
	// state runs one cycle ahead of cmd, so every timer is loaded one
	// cycle before the command it is measured from

	assign tmr_start.trcd = start;
	assign tmr_start.tras = start;
	// reloaded on every write beat but the last so done lines up with the final beat
	assign tmr_start.twr  = (state == bank_pkg::write) && !last_beat;
	assign tmr_start.trp  = (state_nxt == bank_pkg::prech);

	//////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		state_nxt = state;
		case (state)
		bank_pkg::idle:
			if (start)
				state_nxt = bank_pkg::act_row;
		bank_pkg::act_row:
			state_nxt = bank_pkg::trcd_wait;  // trcd >= 2 keeps this wait non-empty
		bank_pkg::trcd_wait:
			if (tmr_done.trcd)
			begin
				if (req_q.write)
					state_nxt = bank_pkg::write;
				else
					state_nxt = bank_pkg::read;
			end
		bank_pkg::write:
			if (last_beat)
			begin
				if (tmr_done.twr && tmr_done.tras)
					state_nxt = bank_pkg::prech;
				else if (tmr_done.twr)
					state_nxt = bank_pkg::wr_end;
				else
					state_nxt = bank_pkg::wr_wait;
			end
		bank_pkg::wr_wait:
			if (tmr_done.twr)
			begin
				if (tmr_done.tras)
					state_nxt = bank_pkg::prech;
				else
					state_nxt = bank_pkg::wr_end;
			end
		bank_pkg::wr_end:
			if (tmr_done.tras)
				state_nxt = bank_pkg::prech;
		bank_pkg::read:
			if (last_beat)
			begin
				if (tmr_done.tras)
					state_nxt = bank_pkg::prech;
				else
					state_nxt = bank_pkg::rd_wait;
			end
		bank_pkg::rd_wait:
			if (tmr_done.tras)
				state_nxt = bank_pkg::prech;
		bank_pkg::prech:
			if (tmr_done.trp)  // trp of 1 skips the wait state
				state_nxt = bank_pkg::idle;
			else
				state_nxt = bank_pkg::prech_wait;
		bank_pkg::prech_wait:
			if (tmr_done.trp)
				state_nxt = bank_pkg::idle;
		default:
			state_nxt = bank_pkg::idle;
		endcase
	end

	// command for the next cycle
	always_comb
	begin
		cmd_nxt = sdram_pkg::NOP;
		if (state == bank_pkg::act_row)
			cmd_nxt = sdram_pkg::ACT_ROW;
		else if (state == bank_pkg::prech)
			cmd_nxt = auto_prech ? sdram_pkg::NOP : sdram_pkg::PRECHARGE;  // row closes itself
		else if (burst_start)
			cmd_nxt = req_q.write ? sdram_pkg::WRITEA : sdram_pkg::READA;
	end

	//////////////////////////////////////////////////////////////////////
	// state and output registers

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			req_d    <= 1'b0;
			state    <= bank_pkg::idle;
			cmd      <= sdram_pkg::NOP;
			row_addr <= 1'b0;
			busy     <= 1'b0;
			req_ack  <= 1'b0;
		end
		else
		begin
			req_d    <= req;
			state    <= state_nxt;
			cmd      <= cmd_nxt;
			row_addr <= (state == bank_pkg::act_row);

			// back in idle with busy still up means trp has just run out
			req_ack <= busy && (state == bank_pkg::idle);
			if (start)
				busy <= 1'b1;
			else if (state == bank_pkg::idle)
				busy <= 1'b0;  // falls together with the ack
		end
	end

endmodule

`default_nettype wire

// ==== bank_pkg.sv ====
// sequencer-internal types for the SDRAM bank: FSM states, latched request and timer handshakes
`default_nettype none

`include "sdr_defs.svh"

package bank_pkg;

	// bank FSM, codes kept from the older controller
	typedef enum logic [3:0] {
		idle       = 4'h5,
		act_row    = 4'hF,
		trcd_wait  = 4'hE,
		write      = 4'h6,  // write bursts running
		wr_wait    = 4'hA,  // waiting on tWR
		wr_end     = 4'h1,  // tWR met, waiting on tRAS
		read       = 4'h7,  // read bursts running
		rd_wait    = 4'hB,  // waiting on tRAS
		prech      = 4'h2,
		prech_wait = 4'hC
	} bank_state_e;

	// request as latched on the accepted edge
	typedef struct packed {
		logic                  write;
		logic [`SDR_LEN_W-1:0] len;  // 1 << len bursts
	} bank_req_t;

	// one load pulse per timer
	typedef struct packed {
		logic trcd;
		logic tras;
		logic twr;
		logic trp;
	} timer_start_t;

	// done levels, same bit order as the load pulses
	typedef struct packed {
		logic trcd;
		logic tras;
		logic twr;
		logic trp;
	} timer_done_t;

endpackage

`default_nettype wire

// ==== burst_counter.sv ====
// burst datapath of the SDRAM bank: latches the request, counts beats and bursts, makes write and read strobes
`default_nettype none

`include "sdr_defs.svh"

module burst_counter (
	input  wire                  clk,
	input  wire                  rst2,
	input  wire                  start,
	input  wire bank_pkg::bank_req_t req_info,
	input  wire                  burst_go,
	output bank_pkg::bank_req_t  req_q,
	output logic                 burst_start,
	output logic                 last_beat,
	output logic                 write_en,
	output logic                 rd_start
);

	localparam int unsigned BEAT_W = $clog2(`SDR_BURST_LEN);
	localparam int unsigned CNT_W  = `SDR_BURST_CNT_W;

	logic [BEAT_W-1:0] beat;         // beat within the current burst
	logic [CNT_W-1:0]  bursts_left;  // bursts still to go after this one
	logic              beat_wrap;

	assign beat_wrap   = (beat == BEAT_W'(`SDR_BURST_LEN - 1));
	assign burst_start = burst_go && (beat == '0);
	assign last_beat   = burst_go && beat_wrap && (bursts_left == '0);

	// request payload, only read once start has loaded it
	always_ff @(posedge clk)
	begin
		if (start)
			req_q <= req_info;
	end

	//////////////////////////////////////////////////////////////////////
	// beat and burst counting

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			beat        <= '0;
			bursts_left <= '0;
			write_en    <= 1'b0;
			rd_start    <= 1'b0;
		end
		else
		begin
			if (start)
			begin
				beat        <= '0;
				bursts_left <= (CNT_W'(1) << req_info.len) - CNT_W'(1);
			end
			else if (burst_go)
			begin
				beat <= beat_wrap ? '0 : beat + 1'b1;
				if (beat_wrap && (bursts_left != '0))
					bursts_left <= bursts_left - 1'b1;
			end

			// registered so both strobes line up with the command output
			write_en <= burst_go && req_q.write;
			rd_start <= burst_start && !req_q.write;  // high in the READA cycle
		end
	end

endmodule

`default_nettype wire

// ==== read_pipe.sv ====
// read strobe generator: delays each read burst start by the CAS latency and stretches it over one burst
`default_nettype none

`include "sdr_defs.svh"

module read_pipe (
	input  wire                  clk,
	input  wire                  rst2,
	input  wire                  rd_start,
	input  wire [`SDR_CAS_W-1:0] cas,
	output logic                 read_en
);

	localparam int unsigned BEAT_W = $clog2(`SDR_BURST_LEN);

	logic [`SDR_CAS_MAX-2:0] sr;
	logic [`SDR_CAS_MAX-1:0] line;        // line[j] is rd_start delayed by j
	logic                    tap;
	logic [BEAT_W-1:0]       beats_left;  // strobe cycles left after this one

	assign line = {sr, rd_start};
	assign tap  = line[cas - 1'b1];  // registered below, so data lands cas after READA

	always_ff @(posedge clk or negedge rst2)
	begin
		if (!rst2)
		begin
			sr         <= '0;
			beats_left <= '0;
			read_en    <= 1'b0;
		end
		else
		begin
			sr <= line[`SDR_CAS_MAX-2:0];

			// a new start reloads, so back to back bursts merge into one strobe
			if (tap)
			begin
				read_en    <= 1'b1;
				beats_left <= BEAT_W'(`SDR_BURST_LEN - 1);
			end
			else if (beats_left != '0)
			begin
				read_en    <= 1'b1;
				beats_left <= beats_left - 1'b1;
			end
			else
				read_en <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== sdr_bank.sv ====
// top of the SDRAM per-bank command sequencer, wiring the FSM, timers, burst counter and read strobe
`default_nettype none

module sdr_bank (
	input  wire                      clk,
	input  wire                      rst2,
	input  wire                      req,
	input  wire bank_pkg::bank_req_t req_info,
	input  wire sdram_pkg::sdr_timing_t timing,
	input  wire                      auto_prech,
	output sdram_pkg::sdr_cmd_e      cmd,
	output logic                     write_en,
	output logic                     read_en,
	output logic                     row_addr,
	output logic                     busy,
	output logic                     req_ack
);

	logic                   start;
	logic                   burst_go;
	logic                   burst_start;
	logic                   last_beat;
	logic                   rd_start;
	bank_pkg::bank_req_t    req_q;
	bank_pkg::timer_start_t tmr_start;
	bank_pkg::timer_done_t  tmr_done;

	//////////////////////////////////////////////////////////////////////
	// control

	bank_ctrl u_bank_ctrl (
		.clk         (clk),
		.rst2        (rst2),
		.req         (req),
		.auto_prech  (auto_prech),
		.tmr_done    (tmr_done),
		.burst_start (burst_start),
		.last_beat   (last_beat),
		.req_q       (req_q),
		.start       (start),
		.burst_go    (burst_go),
		.tmr_start   (tmr_start),
		.cmd         (cmd),
		.row_addr    (row_addr),
		.busy        (busy),
		.req_ack     (req_ack)
	);

	sdr_timers u_sdr_timers (
		.clk       (clk),
		.rst2      (rst2),
		.timing    (timing),
		.tmr_start (tmr_start),
		.tmr_done  (tmr_done)
	);

	//////////////////////////////////////////////////////////////////////
	// datapath strobes

	burst_counter u_burst_counter (
		.clk         (clk),
		.rst2        (rst2),
		.start       (start),
		.req_info    (req_info),
		.burst_go    (burst_go),
		.req_q       (req_q),
		.burst_start (burst_start),
		.last_beat   (last_beat),
		.write_en    (write_en),
		.rd_start    (rd_start)
	);

	read_pipe u_read_pipe (
		.clk      (clk),
		.rst2     (rst2),
		.rd_start (rd_start),
		.cas      (timing.cas),  // CAS latency straight from the timing set
		.read_en  (read_en)
	);

endmodule

`default_nettype wire

// ==== sdr_bank_checker.sv ====
// reference model that samples the SDRAM bank sequencer ports mid-cycle and counts mismatches
`default_nettype none

`include "sdr_defs.svh"

module sdr_bank_checker (
	input  wire                         clk,
	input  wire                         rst2,
	input  wire                         req,
	input  wire bank_pkg::bank_req_t    req_info,
	input  wire sdram_pkg::sdr_timing_t timing,
	input  wire                         auto_prech,
	input  wire sdram_pkg::sdr_cmd_e    cmd,
	input  wire                         write_en,
	input  wire                         read_en,
	input  wire                         row_addr,
	input  wire                         busy,
	input  wire                         req_ack,
	output int                          err_cnt,
	output int                          acc_cnt,
	output int                          ack_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	int   cyc;       // sample index since reset release
	logic req_prev;
	logic valid;     // a transaction has been accepted
	logic t_write;
	logic t_auto;
	int   t_acc;     // cycle of the accepted edge
	int   t_act;     // ACT_ROW cycle
	int   t_col;     // first column command
	int   t_last;    // last cycle of the last burst
	int   t_cas;
	int   t_pre;     // precharge point
	int   t_ack;

	initial
	begin
		err_cnt = 0;
		acc_cnt = 0;
		ack_cnt = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// expected schedule of one transaction

	task automatic accept();
		int n;
		n       = 1 << req_info.len;
		t_write = req_info.write;
		t_auto  = auto_prech;
		t_acc   = cyc;
		t_act   = cyc + 2;
		t_col   = t_act + int'(timing.trcd);
		t_last  = t_col + n * `SDR_BURST_LEN - 1;
		t_cas   = int'(timing.cas);
		// writes wait twr after the last data beat, reads close right after the last burst
		if (t_write)
			t_pre = t_last + int'(timing.twr);
		else
			t_pre = t_last + 1;
		if (t_pre < t_act + int'(timing.tras))
			t_pre = t_act + int'(timing.tras);  // row must stay open for tras
		t_ack   = t_pre + int'(timing.trp);
		valid   = 1'b1;
		acc_cnt++;
	endtask

	function automatic logic in_win(int c, int lo, int hi);
		return (c >= lo) && (c <= hi);
	endfunction

	// busy window of the modelled transaction
	function automatic logic exp_busy(int c);
		return valid && in_win(c, t_acc + 1, t_ack - 1);
	endfunction

	function automatic sdram_pkg::sdr_cmd_e exp_cmd(int c);
		if (!valid)
			return sdram_pkg::NOP;
		if (c == t_act)
			return sdram_pkg::ACT_ROW;
		if (in_win(c, t_col, t_last) && ((c - t_col) % `SDR_BURST_LEN) == 0)
			return t_write ? sdram_pkg::WRITEA : sdram_pkg::READA;
		if (c == t_pre)
			return t_auto ? sdram_pkg::NOP : sdram_pkg::PRECHARGE;
		return sdram_pkg::NOP;
	endfunction

	task automatic check_port(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp)
		begin
			err_cnt++;
			$display("ERROR at %0t ns: cycle %0d %s is %0h, expected %0h",
				$time, cyc, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// per-cycle compare at the falling edge where every port is settled

	always @(negedge clk)
	begin
		if (!rst2)
		begin
			cyc      = 0;
			req_prev = 1'b0;
			valid    = 1'b0;
		end
		else
		begin
			check_port("cmd", cmd, exp_cmd(cyc));
			check_port("write_en", write_en, valid && t_write && in_win(cyc, t_col, t_last));
			check_port("read_en", read_en,
				valid && !t_write && in_win(cyc, t_col + t_cas, t_last + t_cas));
			check_port("row_addr", row_addr, valid && (cyc == t_act));
			check_port("busy", busy, exp_busy(cyc));
			check_port("req_ack", req_ack, valid && (cyc == t_ack));

			if (req_ack)
				ack_cnt++;
			// edges inside the modelled busy window leave the schedule alone
			if (req && !req_prev && !exp_busy(cyc))
				accept();
			req_prev = req;
			cyc++;
		end
	end

endmodule

`default_nettype wire

// ==== sdr_defs.svh ====
// widths and burst length shared by the SDRAM bank sequencer RTL and testbench, pulled in by `include
`ifndef SDR_DEFS_SVH
`define SDR_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// burst geometry

`define SDR_BURST_LEN       4   // beats per WRITEA/READA burst
`define SDR_LEN_W           2   // request length code, 1 << len bursts
`define SDR_BURST_CNT_W     4   // remaining-burst counter

//////////////////////////////////////////////////////////////////////
// timing fields

`define SDR_TIMER_W         4   // trcd, tras, trp, twr
`define SDR_CAS_W           3

// depth of the read strobe delay line, covers cas up to 7
`define SDR_CAS_MAX         7

`endif

// ==== sdr_timers.sv ====
// bank timing counters for tRCD, tRAS, tWR and tRP, loaded by the bank FSM and reporting done levels
`default_nettype none

`include "sdr_defs.svh"

module sdr_timers (
	input  wire                     clk,
	input  wire                     rst2,
	input  wire sdram_pkg::sdr_timing_t timing,
	input  wire bank_pkg::timer_start_t tmr_start,
	output bank_pkg::timer_done_t   tmr_done
);

	localparam int unsigned NUM_TMR = $bits(bank_pkg::timer_start_t);
	localparam int unsigned TW      = `SDR_TIMER_W;

	logic [NUM_TMR-1:0][TW-1:0] load_val;
	logic [NUM_TMR-1:0][TW-1:0] cnt;
	logic [NUM_TMR-1:0]         load;
	logic [NUM_TMR-1:0]         done;

	// lane order follows the struct fields, trcd in the top lane
	assign load_val = {timing.trcd, timing.tras, timing.twr, timing.trp};
	assign load     = tmr_start;
	assign tmr_done = bank_pkg::timer_done_t'(done);

	//////////////////////////////////////////////////////////////////////
	// down-counters, one per lane

	for (genvar i = 0; i < NUM_TMR; i++)
	begin : g_tmr
		always_ff @(posedge clk or negedge rst2)
		begin
			if (!rst2)
				cnt[i] <= '0;  // idle timers read as done
			else if (load[i])
				cnt[i] <= load_val[i];
			else if (cnt[i] != '0)
				cnt[i] <= cnt[i] - 1'b1;  // holds at zero
		end

		// high N cycles after a load of N and stays up until the next load,
		// so tRAS can still be tested long after the row opened
		assign done[i] = (cnt[i] <= TW'(1));
	end

endmodule

`default_nettype wire

// ==== sdram_pkg.sv ====
// SDRAM-side types: command encoding on the bus and the timing set fed to the bank sequencer
`default_nettype none

`include "sdr_defs.svh"

package sdram_pkg;

	// command code as seen on {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		LOAD_MR      = 3'b000,
		AUTO_REFRESH = 3'b001,
		PRECHARGE    = 3'b010,
		ACT_ROW      = 3'b011,
		WRITEA       = 3'b100,  // write with auto-precharge
		READA        = 3'b101,  // read with auto-precharge
		BURST_STOP   = 3'b110,
		NOP          = 3'b111
	} sdr_cmd_e;

	// quasi-static timing, in clock cycles
	typedef struct packed {
		logic [`SDR_TIMER_W-1:0] trcd;  // ACT to first column command
		logic [`SDR_TIMER_W-1:0] tras;  // ACT to precharge
		logic [`SDR_TIMER_W-1:0] trp;   // precharge to next access
		logic [`SDR_TIMER_W-1:0] twr;   // last write data to precharge
		logic [`SDR_CAS_W-1:0]   cas;   // READA to first read data
	} sdr_timing_t;

endpackage

`default_nettype wire

// ==== tb_sdr_bank.sv ====
// testbench top for the SDRAM bank sequencer: clock, reset, seeded random transactions, watchdog
`default_nettype none

`include "sdr_defs.svh"

module tb_sdr_bank;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DLY   = 2;
	localparam int RST_CYCLES  = 10;
	localparam int N_TXN       = 60;
	localparam int TXN_CYCLES  = 80;  // worst case, trcd 15, 8 bursts, twr 15, trp 15
	localparam int GAP_CYCLES  = 12;  // lets a read strobe tail drain before the next request
	localparam int WATCHDOG_NS = (RST_CYCLES + N_TXN * (TXN_CYCLES + GAP_CYCLES + 8)) * CLK_PERIOD;

	logic                   clk;
	logic                   rst2;
	logic                   req;
	bank_pkg::bank_req_t    req_info;
	sdram_pkg::sdr_timing_t timing;
	logic                   auto_prech;
	sdram_pkg::sdr_cmd_e    cmd;
	logic                   write_en;
	logic                   read_en;
	logic                   row_addr;
	logic                   busy;
	logic                   req_ack;
	int                     err_cnt;
	int                     acc_cnt;
	int                     ack_cnt;
	int                     seed;
	int                     ignored_cnt;
	int                     total_err;

	sdr_bank u_sdr_bank (
		.clk        (clk),
		.rst2       (rst2),
		.req        (req),
		.req_info   (req_info),
		.timing     (timing),
		.auto_prech (auto_prech),
		.cmd        (cmd),
		.write_en   (write_en),
		.read_en    (read_en),
		.row_addr   (row_addr),
		.busy       (busy),
		.req_ack    (req_ack)
	);

	sdr_bank_checker u_sdr_bank_checker (
		.clk        (clk),
		.rst2       (rst2),
		.req        (req),
		.req_info   (req_info),
		.timing     (timing),
		.auto_prech (auto_prech),
		.cmd        (cmd),
		.write_en   (write_en),
		.read_en    (read_en),
		.row_addr   (row_addr),
		.busy       (busy),
		.req_ack    (req_ack),
		.err_cnt    (err_cnt),
		.acc_cnt    (acc_cnt),
		.ack_cnt    (ack_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	function automatic int rand_range(int lo, int hi);
		int unsigned u;
		u = $random(seed);
		return lo + int'(u % (hi - lo + 1));
	endfunction

	task automatic run_txn();
		logic extra;
		// timing and auto_prech only change while the bank is idle
		timing.trcd = `SDR_TIMER_W'(rand_range(2, 15));
		timing.tras = `SDR_TIMER_W'(rand_range(1, 15));
		timing.trp  = `SDR_TIMER_W'(rand_range(1, 15));
		timing.twr  = `SDR_TIMER_W'(rand_range(1, 15));
		timing.cas  = `SDR_CAS_W'(rand_range(1, 7));
		auto_prech  = rand_range(0, 1);
		req_info    = bank_pkg::bank_req_t'(rand_range(0, 7));
		extra       = (rand_range(0, 3) == 0);
		next_cycle();
		req = 1'b1;  // rising edge, bank idle
		next_cycle();
		req      = 1'b0;
		req_info = bank_pkg::bank_req_t'(rand_range(0, 7));  // latched copy must not follow
		if (extra)
		begin
			next_cycle();
			req = 1'b1;  // this edge lands while busy
			ignored_cnt++;
			next_cycle();
			req = 1'b0;
		end
		while (!req_ack)
			next_cycle();
		repeat (GAP_CYCLES)
			next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		seed        = 32'h34;
		ignored_cnt = 0;
		rst2        = 1'b0;
		req         = 1'b0;
		req_info    = '0;
		auto_prech  = 1'b0;
		timing      = '{trcd: 2, tras: 1, trp: 1, twr: 1, cas: 1};

		repeat (RST_CYCLES)
			@(posedge clk);
		#DRIVE_DLY;
		rst2 = 1'b1;
		repeat (4)
			next_cycle();  // idle outputs checked here too

		repeat (N_TXN)
			run_txn();

		total_err = err_cnt;
		if (acc_cnt != N_TXN)
		begin
			total_err++;
			$display("ERROR at %0t ns: %0d requests accepted, expected %0d",
				$time, acc_cnt, N_TXN);
		end
		if (ack_cnt != acc_cnt)
		begin
			total_err++;
			$display("ERROR at %0t ns: %0d acknowledges for %0d accepted requests",
				$time, ack_cnt, acc_cnt);
		end

		$display("errors %0d, accepted %0d, acknowledged %0d, ignored edges %0d",
			total_err, acc_cnt, ack_cnt, ignored_cnt);
		if (total_err == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog, sized for every transaction at its worst case
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run stopped after %0d ns waiting for an acknowledge", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
sdram_pkg.sv
bank_pkg.sv
sdr_timers.sv
burst_counter.sv
read_pipe.sv
bank_ctrl.sv
sdr_bank.sv
sdr_bank_checker.sv
tb_sdr_bank.sv
